//--- testbench/frames_golden.txt
# f verdict mode paylen(hex) starts a frame; mode 0 good fcs, 1 corrupt fcs, 2 dv drops early
# following lines hold more frame bytes, preamble through padding; the fcs is added by the tb
f 1 0 20 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 34 00 00 00 00 40 11 f7 03 c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 20 00 00 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23 24 25 26 27
f 1 0 12 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 26 00 00 00 00 40 11 f7 11 c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 12 00 00 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 00 00 00 00 00 00 00 00
f 0 1 20 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 34 00 00 00 00 40 11 f7 03 c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 20 00 00 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f 40 41 42 43 44 45 46 47
f 0 0 1a 55 55 55 55 55 55 55 5d 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 2e 00 00 00 00 40 11 f7 09 c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 1a 00 00 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61
f 0 0 1a 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 86 dd
45 00 00 2e 00 00 00 00 40 11 f7 09 c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 1a 00 00 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61
f 0 0 1a 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 2e 00 00 00 00 40 06 f7 14 c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 1a 00 00 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61
f 0 0 1a 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 2e 00 00 00 00 00 11 37 0a c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 1a 00 00 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61
f 0 0 1a 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 2e 00 00 00 00 40 11 f7 08 c0 a8 01 01 c0 a8 01 65
04 00 04 01 00 1a 00 00 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61
f 0 0 1a 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 2e 00 00 00 00 40 11 f7 0a c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 1a 00 00 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61
f 0 2 1a 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 2e 00 00 00 00 40 11 f7 09 c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 1a 00 00 50 51
f 1 0 1a 55 55 55 55 55 55 55 d5 02 00 00 00 00 01 02 00 00 00 00 02 08 00
45 00 00 2e 00 00 00 00 40 11 f7 09 c0 a8 01 01 c0 a8 01 64
04 00 04 01 00 1a 00 00 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f 60 61

//--- sources.f
design/rx_pkg.sv
design/eth_crc32.sv
design/gmii_frame_parser.sv
design/frame_buffer.sv
design/payload_reader.sv
design/eth_udp_rx.sv
testbench/rx_checker.sv
testbench/rx_assert.sv
testbench/tb_eth_udp_rx.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_udp_rx \
		-f sources.f -o sim
	./obj_dir/sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -Wall --top-module tb_eth_udp_rx -f sources.f

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_eth_udp_rx.sv
`timescale 1ns/1ns

module tb_eth_udp_rx;
    import rx_pkg::*;

    localparam int IFG = 20;

    logic             gmii_clk;
    logic             gmii_rst;
    logic             gmii_rx_dv;
    logic [7:0]       gmii_rd;
    logic [7:0]       dout;
    logic             dout_vld;
    logic             dout_sop;
    logic             dout_eop;
    logic [LEN_W-1:0] dout_len;

    logic [7:0]  q_bytes [$];
    int          f_start [$];
    int          f_len [$];
    int          f_verdict [$];
    int          f_mode [$];
    int          f_pay [$];
    logic [31:0] lfsr;
    longint      wd_cycles;
    bit          loaded;
    int          fd;

    eth_udp_rx #(.ifg_cycles(IFG)) dut (
        .gmii_clk (gmii_clk), .gmii_rst (gmii_rst),
        .gmii_rx_dv (gmii_rx_dv), .gmii_rd (gmii_rd),
        .dout (dout), .dout_vld (dout_vld), .dout_sop (dout_sop),
        .dout_eop (dout_eop), .dout_len (dout_len)
    );

    rx_checker u_chk (
        .gmii_clk (gmii_clk), .gmii_rst (gmii_rst), .dout (dout), .dout_vld (dout_vld),
        .dout_sop (dout_sop), .dout_eop (dout_eop), .dout_len (dout_len)
    );

    initial begin
        gmii_clk = 1'b0;
        forever #50 gmii_clk = ~gmii_clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c ^ 32'(b);
        repeat (8) r = r[0] ? (r >> 1) ^ 32'hedb88320 : r >> 1;
        return r;
    endfunction

    function automatic int hex_val(input byte c);
        if (c >= 8'h30 && c <= 8'h39) return int'(c) - 48;
        if (c >= 8'h61 && c <= 8'h66) return int'(c) - 87;
        return -1;
    endfunction

    task automatic load_frames(input int fh);
        string line;
        int    tok [$];
        int    v, d, first, code;
        bit    in_tok;
        while (!$feof(fh)) begin
            line = "";
            code = $fgets(line, fh);
            tok.delete();
            v = 0;
            in_tok = 0;
            first = (line.len() > 1 && line[0] == "f" && line[1] == " ") ? 2 : 0;
            if (code == 0 || line.len() == 0 || line[0] == "#") continue;
            for (int i = first; i <= line.len(); i++) begin
                d = (i < line.len()) ? hex_val(line[i]) : -1;
                if (d >= 0) begin
                    v = v * 16 + d;
                    in_tok = 1;
                end else if (in_tok) begin
                    tok.push_back(v);
                    v = 0;
                    in_tok = 0;
                end
            end
            if (first == 2) begin   // new frame with verdict, mode and length
                f_verdict.push_back(tok.pop_front());
                f_mode.push_back(tok.pop_front());
                f_pay.push_back(tok.pop_front());
                f_start.push_back(q_bytes.size());
                f_len.push_back(0);
            end
            foreach (tok[k]) q_bytes.push_back(tok[k][7:0]);
            if (f_len.size() > 0) f_len[f_len.size() - 1] += tok.size();
        end
    endtask

    task automatic drive_byte(input logic [7:0] b);
        @(negedge gmii_clk);
        gmii_rx_dv = 1'b1;
        gmii_rd    = b;
    endtask

    task automatic send_frame(input int idx);
        logic [31:0] crc;
        logic [7:0]  b;
        crc = '1;
        for (int k = 0; k < f_len[idx]; k++) begin
            b = q_bytes[f_start[idx] + k];
            drive_byte(b);
            if (k >= 8) crc = crc_update(crc, b);   // hashed after the sfd
        end
        if (f_mode[idx] != 2) begin
            crc = ~crc;
            for (int j = 0; j < 4; j++) begin
                b = crc[8*j +: 8];
                if (f_mode[idx] == 1 && j == 0) b = ~b;
                drive_byte(b);
            end
        end
        @(negedge gmii_clk);
        gmii_rx_dv = 1'b0;
        gmii_rd    = 8'h00;
    endtask

    task automatic idle_gap();
        logic [3:0] extra;
        extra = '0;
        repeat (4) begin
            lfsr  = lfsr_next(lfsr);
            extra = {extra[2:0], lfsr[0]};
        end
        repeat (IFG + 2 + int'(extra)) @(negedge gmii_clk);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    task automatic run_tests();
        int n, total;
        load_frames(fd);
        wd_cycles = 200;
        foreach (f_len[i]) wd_cycles += f_len[i] + 4 + 40;
        loaded = 1;
        repeat (8) @(negedge gmii_clk);
        gmii_rst = 1'b0;
        repeat (4) @(negedge gmii_clk);
        foreach (f_len[i]) begin
            if (f_verdict[i] == 1) begin
                u_chk.add_frame(f_pay[i]);
                for (int k = 0; k < f_pay[i]; k++)
                    u_chk.add_byte(q_bytes[f_start[i] + 8 + HDR_BYTES + k]);
            end
            send_frame(i);
            idle_gap();
        end
        n = 0;
        while (u_chk.pending() != 0 && n < 100) begin
            @(negedge gmii_clk);
            n++;
        end
        repeat (20) @(negedge gmii_clk);
        if (u_chk.pending() != 0)
            $display("%0d expected frames never appeared on dout", u_chk.pending());
        total = u_chk.n_mismatch + u_chk.n_extra + u_chk.pending();
        $display("errors: mismatch %0d, extra %0d, missing frames %0d",
                 u_chk.n_mismatch, u_chk.n_extra, u_chk.pending());
        if (total == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    initial begin
        gmii_rst   = 1'b1;
        gmii_rx_dv = 1'b0;
        gmii_rd    = 8'h00;
        lfsr       = 32'hbe1e;
        loaded     = 0;
        fd = $fopen("testbench/frames_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden frame file");
            $display("=== FAIL ===");
            $finish;
        end else begin
            run_tests();
        end
    end

    // watchdog
    initial begin
        wait (loaded);
        #(wd_cycles * 100);
        $display("timeout after %0d cycles, %0d frames still expected",
                 wd_cycles, u_chk.pending());
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- testbench/rx_assert.sv
`timescale 1ns/1ns

module rx_assert (
    input logic                     gmii_clk,
    input logic                     gmii_rst,
    input logic                     dout_vld,
    input logic                     dout_sop,
    input logic                     dout_eop,
    input logic [rx_pkg::LEN_W-1:0] dout_len
);
    a_marker_vld: assert property (@(posedge gmii_clk) disable iff (gmii_rst)
        (dout_sop || dout_eop) |-> dout_vld)
        else $error("dout_sop or dout_eop without dout_vld");

    a_rst_quiet: assert property (@(posedge gmii_clk) gmii_rst |=> !dout_vld)
        else $error("dout_vld high after a reset cycle");

    // length only moves on a sop
    a_len_stable: assert property (@(posedge gmii_clk) disable iff (gmii_rst)
        (dout_vld && !dout_sop) |-> $stable(dout_len))
        else $error("dout_len changed inside a frame");
endmodule

bind eth_udp_rx rx_assert u_assert (
    .gmii_clk (gmii_clk),
    .gmii_rst (gmii_rst),
    .dout_vld (dout_vld),
    .dout_sop (dout_sop),
    .dout_eop (dout_eop),
    .dout_len (dout_len)
);

//--- testbench/rx_checker.sv
`timescale 1ns/1ns

module rx_checker (
    input  logic                     gmii_clk,
    input  logic                     gmii_rst,
    input  logic [7:0]               dout,
    input  logic                     dout_vld,
    input  logic                     dout_sop,
    input  logic                     dout_eop,
    input  logic [rx_pkg::LEN_W-1:0] dout_len
);
    logic [7:0] exp_byte [$];
    int         exp_len [$];
    int         pos;
    int         n_mismatch;
    int         n_extra;

    initial begin
        pos        = 0;
        n_mismatch = 0;
        n_extra    = 0;
    end

    ////////////////////////////////////////////////////////////
    // expected frames, filled in by the testbench

    task automatic add_frame(input int len);
        exp_len.push_back(len);
    endtask

    task automatic add_byte(input logic [7:0] b);
        exp_byte.push_back(b);
    endtask

    function automatic int pending();
        return exp_len.size();
    endfunction

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
            n_mismatch++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // output compare

    always @(posedge gmii_clk) begin
        if (!gmii_rst) begin
            if ((dout_sop || dout_eop) && !dout_vld) begin
                $display("frame marker seen without dout_vld at %0t", $time);
                n_mismatch++;
            end
            if (dout_vld && exp_len.size() == 0) begin
                $display("extra output byte %h while no frame was expected at %0t", dout, $time);
                n_extra++;
            end else if (dout_vld) begin
                check_value("dout", 16'(dout), 16'(exp_byte[0]));
                check_value("dout_sop", 16'(dout_sop), 16'(pos == 0));
                check_value("dout_eop", 16'(dout_eop), 16'(pos == exp_len[0] - 1));
                check_value("dout_len", 16'(dout_len), 16'(exp_len[0]));
                void'(exp_byte.pop_front());
                pos++;
                if (pos == exp_len[0]) begin
                    void'(exp_len.pop_front());
                    pos = 0;
                end
            end
        end
    end

endmodule

//--- design/eth_udp_rx.sv
`timescale 1ns/1ns

module eth_udp_rx #(
    parameter logic [31:0] local_ip   = {8'd192, 8'd168, 8'd1, 8'd100},
    parameter int          ifg_cycles = 20,
    parameter int          data_depth = 2048,
    parameter int          meta_depth = 8
) (
    input  logic                     gmii_clk,
    input  logic                     gmii_rst,
    input  logic                     gmii_rx_dv,
    input  logic [7:0]               gmii_rd,
    output logic [7:0]               dout,
    output logic                     dout_vld,
    output logic                     dout_sop,
    output logic                     dout_eop,
    output logic [rx_pkg::LEN_W-1:0] dout_len
);
    import rx_pkg::*;

    // parser to buffer
    logic             data_wr;
    logic [7:0]       data_byte;
    logic             data_sop;
    logic             data_eop;
    logic [11:0]      data_free;
    logic             meta_wr;
    logic [LEN_W-1:0] meta_len;
    logic             meta_good;
    logic             meta_full;

    // buffer to reader
    logic             data_rd;
    logic [7:0]       data_byte_q;
    logic             data_sop_q;
    logic             data_eop_q;
    logic             data_empty;
    logic             meta_rd;
    logic [LEN_W-1:0] meta_len_q;
    logic             meta_good_q;
    logic             meta_empty;

    gmii_frame_parser #(
        .local_ip   (local_ip),
        .ifg_cycles (ifg_cycles)
    ) u_parser (
        .gmii_clk   (gmii_clk),
        .gmii_rst   (gmii_rst),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rd    (gmii_rd),
        .data_free  (data_free),
        .meta_full  (meta_full),
        .data_wr    (data_wr),
        .data_byte  (data_byte),
        .data_sop   (data_sop),
        .data_eop   (data_eop),
        .meta_wr    (meta_wr),
        .meta_len   (meta_len),
        .meta_good  (meta_good)
    );

    frame_buffer #(
        .data_depth (data_depth),
        .meta_depth (meta_depth)
    ) u_buffer (
        .gmii_clk    (gmii_clk),
        .gmii_rst    (gmii_rst),
        .data_wr     (data_wr),
        .data_byte   (data_byte),
        .data_sop    (data_sop),
        .data_eop    (data_eop),
        .data_rd     (data_rd),
        .data_byte_q (data_byte_q),
        .data_sop_q  (data_sop_q),
        .data_eop_q  (data_eop_q),
        .data_empty  (data_empty),
        .data_free   (data_free),
        .meta_wr     (meta_wr),
        .meta_len    (meta_len),
        .meta_good   (meta_good),
        .meta_rd     (meta_rd),
        .meta_len_q  (meta_len_q),
        .meta_good_q (meta_good_q),
        .meta_empty  (meta_empty),
        .meta_full   (meta_full)
    );

    payload_reader u_reader (
        .gmii_clk    (gmii_clk),
        .gmii_rst    (gmii_rst),
        .data_byte_q (data_byte_q),
        .data_sop_q  (data_sop_q),
        .data_eop_q  (data_eop_q),
        .data_empty  (data_empty),
        .meta_len_q  (meta_len_q),
        .meta_good_q (meta_good_q),
        .meta_empty  (meta_empty),
        .data_rd     (data_rd),
        .meta_rd     (meta_rd),
        .dout        (dout),
        .dout_vld    (dout_vld),
        .dout_sop    (dout_sop),
        .dout_eop    (dout_eop),
        .dout_len    (dout_len)
    );

endmodule

//--- design/payload_reader.sv
`timescale 1ns/1ns

module payload_reader (
    input  logic                     gmii_clk,
    input  logic                     gmii_rst,
    input  logic [7:0]               data_byte_q,
    input  logic                     data_sop_q,
    input  logic                     data_eop_q,
    input  logic                     data_empty,
    input  logic [rx_pkg::LEN_W-1:0] meta_len_q,
    input  logic                     meta_good_q,
    input  logic                     meta_empty,
    output logic                     data_rd,
    output logic                     meta_rd,
    output logic [7:0]               dout,
    output logic                     dout_vld,
    output logic                     dout_sop,
    output logic                     dout_eop,
    output logic [rx_pkg::LEN_W-1:0] dout_len
);
    logic draining;

    // a record means the whole frame is already stored
    assign data_rd = draining && !data_empty;
    assign meta_rd = data_rd && data_eop_q;

    always_ff @(posedge gmii_clk) begin
        if (gmii_rst) begin
            draining <= 1'b0;
            dout_vld <= 1'b0;
            dout_sop <= 1'b0;
            dout_eop <= 1'b0;
        end else begin
            if (meta_rd)
                draining <= 1'b0;
            else if (!meta_empty)
                draining <= 1'b1;
            dout_vld <= data_rd && meta_good_q;   // bad frames drain silently
            dout_sop <= data_rd && meta_good_q && data_sop_q;
            dout_eop <= meta_rd && meta_good_q;
        end
    end

    always_ff @(posedge gmii_clk) begin
        dout <= data_byte_q;
        if (data_rd && data_sop_q)
            dout_len <= meta_len_q;   // held until the next frame
    end

endmodule

//--- design/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer #(
    parameter int data_depth = 2048,
    parameter int meta_depth = 8
) (
    input  logic                     gmii_clk,
    input  logic                     gmii_rst,
    input  logic                     data_wr,
    input  logic [7:0]               data_byte,
    input  logic                     data_sop,
    input  logic                     data_eop,
    input  logic                     data_rd,
    output logic [7:0]               data_byte_q,
    output logic                     data_sop_q,
    output logic                     data_eop_q,
    output logic                     data_empty,
    output logic [11:0]              data_free,
    input  logic                     meta_wr,
    input  logic [rx_pkg::LEN_W-1:0] meta_len,
    input  logic                     meta_good,
    input  logic                     meta_rd,
    output logic [rx_pkg::LEN_W-1:0] meta_len_q,
    output logic                     meta_good_q,
    output logic                     meta_empty,
    output logic                     meta_full
);
    import rx_pkg::*;

    localparam int DA_W = $clog2(data_depth);
    localparam int MA_W = $clog2(meta_depth);

    logic [9:0]      data_mem [data_depth];   // sop, eop, byte
    logic [DA_W-1:0] data_wp, data_rp;
    logic [DA_W:0]   data_cnt;
    logic [LEN_W:0]  meta_mem [meta_depth];   // good, len
    logic [MA_W-1:0] meta_wp, meta_rp;
    logic [MA_W:0]   meta_cnt;

    ////////////////////////////////////////////////////////////
    // payload entries

    always_ff @(posedge gmii_clk) begin
        if (data_wr)
            data_mem[data_wp] <= {data_sop, data_eop, data_byte};
        if (meta_wr)
            meta_mem[meta_wp] <= {meta_good, meta_len};
    end

    always_ff @(posedge gmii_clk) begin
        if (gmii_rst) begin
            data_wp  <= '0;
            data_rp  <= '0;
            data_cnt <= '0;
        end else begin
            if (data_wr)
                data_wp <= data_wp + 1'b1;
            if (data_rd)
                data_rp <= data_rp + 1'b1;
            case ({data_wr, data_rd})
                2'b10:   data_cnt <= data_cnt + 1'b1;
                2'b01:   data_cnt <= data_cnt - 1'b1;
                default: data_cnt <= data_cnt;
            endcase
        end
    end

    assign {data_sop_q, data_eop_q, data_byte_q} = data_mem[data_rp];   // fall-through head
    assign data_empty = (data_cnt == '0);
    assign data_free  = 12'(data_depth) - 12'(data_cnt);

    ////////////////////////////////////////////////////////////
    // frame records

    always_ff @(posedge gmii_clk) begin
        if (gmii_rst) begin
            meta_wp  <= '0;
            meta_rp  <= '0;
            meta_cnt <= '0;
        end else begin
            if (meta_wr)
                meta_wp <= meta_wp + 1'b1;
            if (meta_rd)
                meta_rp <= meta_rp + 1'b1;
            case ({meta_wr, meta_rd})
                2'b10:   meta_cnt <= meta_cnt + 1'b1;
                2'b01:   meta_cnt <= meta_cnt - 1'b1;
                default: meta_cnt <= meta_cnt;
            endcase
        end
    end

    assign {meta_good_q, meta_len_q} = meta_mem[meta_rp];
    assign meta_empty = (meta_cnt == '0);
    assign meta_full  = (meta_cnt == (MA_W + 1)'(meta_depth));

endmodule

//--- design/gmii_frame_parser.sv
`timescale 1ns/1ns

module gmii_frame_parser #(
    parameter logic [31:0] local_ip   = {8'd192, 8'd168, 8'd1, 8'd100},
    parameter int          ifg_cycles = 20
) (
    input  logic                     gmii_clk,
    input  logic                     gmii_rst,
    input  logic                     gmii_rx_dv,
    input  logic [7:0]               gmii_rd,
    input  logic [11:0]              data_free,
    input  logic                     meta_full,
    output logic                     data_wr,
    output logic [7:0]               data_byte,
    output logic                     data_sop,
    output logic                     data_eop,
    output logic                     meta_wr,
    output logic [rx_pkg::LEN_W-1:0] meta_len,
    output logic                     meta_good
);
    import rx_pkg::*;

    localparam int IFG_W = $clog2(ifg_cycles) + 1;

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_PRE  = 3'd1;
    localparam logic [2:0] S_HDR  = 3'd2;
    localparam logic [2:0] S_PAY  = 3'd3;
    localparam logic [2:0] S_FCS  = 3'd4;
    localparam logic [2:0] S_ERR  = 3'd5;   // also waits out the gap
    localparam logic [2:0] S_FIN  = 3'd6;

    logic [2:0]       state, state_nx;
    logic             rx_flag;
    logic [IFG_W-1:0] cnt_ifg;
    logic             end_ifg;
    logic             start;
    logic             in_vld;
    logic [7:0]       in_byte;
    logic [LEN_W-1:0] cnt;
    rx_header_u       hdr, hdr_nx;
    logic [19:0]      csum_sum;
    logic [16:0]      csum_f1;
    logic [15:0]      csum_f2;
    logic [15:0]      ip_len;
    logic             hdr_ok;
    logic             room;
    logic [LEN_W-1:0] pay_len, pay_end;
    logic [23:0]      fcs_rx;
    logic [31:0]      fcs;
    logic             fcs_ok;
    logic             good;

    ////////////////////////////////////////////////////////////
    // input register and frame gap

    assign start   = (state == S_IDLE) && !rx_flag && gmii_rx_dv && (gmii_rd == PRE_BYTE);
    assign end_ifg = rx_flag && !gmii_rx_dv && (cnt_ifg == IFG_W'(ifg_cycles - 1));

    always_ff @(posedge gmii_clk) begin
        if (gmii_rst) begin
            rx_flag <= 1'b0;
            cnt_ifg <= '0;
            in_vld  <= 1'b0;
        end else begin
            if (start)
                rx_flag <= 1'b1;
            else if (end_ifg)
                rx_flag <= 1'b0;
            if (gmii_rx_dv || end_ifg)
                cnt_ifg <= '0;
            else if (rx_flag)
                cnt_ifg <= cnt_ifg + 1'b1;
            in_vld <= gmii_rx_dv && (rx_flag || start);
        end
    end

    always_ff @(posedge gmii_clk) begin
        in_byte <= gmii_rd;
    end

    ////////////////////////////////////////////////////////////
    // header decode on the last header byte

    assign hdr_nx = {hdr.words[16][7:0], hdr.words[15:0], in_byte};
    assign ip_len = hdr_nx.fields.total_len;

    // ones' complement sum over the ten ip header words
    always_comb begin
        csum_sum = '0;
        for (int i = 0; i < 10; i++) begin
            csum_sum = csum_sum + 20'(hdr_nx.words[i]);
        end
        csum_f1 = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
        csum_f2 = csum_f1[15:0] + 16'(csum_f1[16]);
    end

    assign hdr_ok = (hdr_nx.fields.ethertype == ETHERTYPE_IPV4) &&
                    (hdr_nx.fields.ver_ihl == IP_VER_IHL) &&
                    (hdr_nx.fields.ttl != 8'd0) &&
                    (hdr_nx.fields.proto == IP_PROTO_UDP) &&
                    (hdr_nx.fields.dst_ip == local_ip) &&
                    (ip_len > 16'(IP_HDR_BYTES)) &&
                    (ip_len <= 16'(IP_HDR_BYTES + MAX_PAYLOAD)) &&
                    (csum_f2 == 16'hffff);

    assign room    = (data_free >= 12'(MAX_PAYLOAD)) && !meta_full;
    assign pay_end = (pay_len < LEN_W'(MIN_PAYLOAD)) ? LEN_W'(MIN_PAYLOAD) : pay_len;
    assign fcs_ok  = ({fcs_rx, in_byte} == fcs);

    ////////////////////////////////////////////////////////////
    // frame FSM

    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE: begin
                if (start)
                    state_nx = S_PRE;
            end
            S_PRE: begin
                if (!in_vld)
                    state_nx = S_ERR;
                else if (cnt == LEN_W'(7))
                    state_nx = (in_byte == SFD_BYTE && room) ? S_HDR : S_ERR;
                else if (in_byte != PRE_BYTE)
                    state_nx = S_ERR;
            end
            S_HDR: begin
                if (!in_vld)
                    state_nx = S_ERR;
                else if (cnt == LEN_W'(HDR_BYTES - 1))
                    state_nx = hdr_ok ? S_PAY : S_ERR;
            end
            S_PAY: begin
                if (!in_vld)
                    state_nx = S_FIN;   // abort, close with a bad record
                else if (cnt == pay_end - 1'b1)
                    state_nx = S_FCS;
            end
            S_FCS: begin
                if (!in_vld || cnt == LEN_W'(FCS_BYTES - 1))
                    state_nx = S_FIN;
            end
            S_FIN: state_nx = S_ERR;
            S_ERR: begin
                if (!rx_flag)
                    state_nx = S_IDLE;
            end
            default: state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge gmii_clk) begin
        if (gmii_rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nx;
            if (state_nx != state)
                cnt <= '0;   // counts bytes within a state
            else if (in_vld)
                cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge gmii_clk) begin
        if (state == S_HDR && in_vld) begin
            hdr     <= hdr_nx;
            pay_len <= LEN_W'(ip_len - 16'(IP_HDR_BYTES));
        end
        if (state == S_FCS && in_vld)
            fcs_rx <= {fcs_rx[15:0], in_byte};
        good <= (state == S_FCS) && in_vld && fcs_ok;   // read only in S_FIN
    end

    eth_crc32 u_crc (
        .gmii_clk  (gmii_clk),
        .gmii_rst  (gmii_rst),
        .crc_clear (state == S_IDLE),
        .crc_en    (in_vld && (state == S_HDR || state == S_PAY)),
        .crc_byte  (in_byte),
        .fcs       (fcs)
    );

    // padding past pay_len is hashed, never stored
    assign data_wr   = (state == S_PAY) && (cnt < pay_len);
    assign data_byte = in_byte;
    assign data_sop  = (cnt == '0);
    assign data_eop  = !in_vld || (cnt == pay_len - 1'b1);
    assign meta_wr   = (state == S_FIN);
    assign meta_len  = pay_len;
    assign meta_good = good;

endmodule

//--- design/eth_crc32.sv
`timescale 1ns/1ns

module eth_crc32 (
    input  logic        gmii_clk,
    input  logic        gmii_rst,
    input  logic        crc_clear,
    input  logic        crc_en,
    input  logic [7:0]  crc_byte,
    output logic [31:0] fcs
);
    localparam logic [31:0] POLY = 32'hedb88320;   // 0x04c11db7 bit-reversed

    logic [31:0] crc;

    // one byte, lsb first as it goes out on the wire
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            r = (r[0] ^ d[i]) ? ((r >> 1) ^ POLY) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge gmii_clk) begin
        if (gmii_rst || crc_clear)
            crc <= '1;
        else if (crc_en)
            crc <= crc_step(crc, crc_byte);
    end

    // low byte is sent first, so it lands in the top of fcs
    assign fcs = ~{crc[7:0], crc[15:8], crc[23:16], crc[31:24]};

endmodule

//--- design/rx_pkg.sv
package rx_pkg;

    ////////////////////////////////////////////////////////////
    // framing and protocol constants
    localparam logic [7:0]  PRE_BYTE       = 8'h55;
    localparam logic [7:0]  SFD_BYTE       = 8'hd5;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    localparam int HDR_BYTES    = 34;   // 14 eth + 20 ipv4
    localparam int IP_HDR_BYTES = 20;
    localparam int MIN_PAYLOAD  = 26;   // pads the frame to 64 bytes
    localparam int FCS_BYTES    = 4;
    localparam int LEN_W        = 11;
    localparam int MAX_PAYLOAD  = 1480;

    ////////////////////////////////////////////////////////////
    // received header, first byte on the wire in the top bits
    typedef union packed {
        struct packed {
            logic [47:0] dst_mac;
            logic [47:0] src_mac;
            logic [15:0] ethertype;
            logic [7:0]  ver_ihl;
            logic [7:0]  tos;
            logic [15:0] total_len;
            logic [15:0] id;
            logic [15:0] flags_frag;
            logic [7:0]  ttl;
            logic [7:0]  proto;
            logic [15:0] hdr_csum;
            logic [31:0] src_ip;
            logic [31:0] dst_ip;
        } fields;
        logic [16:0][15:0] words;   // words[9:0] span the ip header
    } rx_header_u;

endpackage
